//--- design/cpu_pkg.sv
package cpu_pkg;

	localparam int data_width = 32;
	localparam int reg_count  = 32;
	// Byte offset bits below a word address
	localparam int addr_lsb   = 2;

	typedef logic [data_width-1:0] word_t;
	typedef logic [4:0]            reg_addr_t;

	// R-type view of an instruction word
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		reg_addr_t  shamt;
		logic [5:0] funct;
	} r_fields_t;

	// I-type view that also carries the jump index across rs, rt and imm
	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_t;

	// Three-bit ALU control codes
	typedef enum logic [2:0] {
		alu_and  = 3'b000,
		alu_or   = 3'b001,
		alu_add  = 3'b010,
		alu_sltu = 3'b011,
		alu_xor  = 3'b100,
		alu_nor  = 3'b101,
		alu_sub  = 3'b110,
		alu_slt  = 3'b111
	} alu_op_e;

	// Same as funct[1:0] of the shift instructions
	typedef enum logic [1:0] {
		shift_sll = 2'b00,
		shift_srl = 2'b10,
		shift_sra = 2'b11
	} shift_op_e;

	typedef enum logic [4:0] {
		st_fetch     = 5'b00001,
		st_decode    = 5'b00010,
		st_execute   = 5'b00100,
		st_memory    = 5'b01000,
		st_writeback = 5'b10000
	} cpu_state_e;

	typedef enum logic [2:0] {
		cls_nop,
		cls_alu_reg,
		cls_alu_imm,
		cls_shift,
		cls_lui,
		cls_load,
		cls_store,
		cls_branch_jump
	} instr_class_e;

	// Opcodes
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_j       = 6'b000010;
	localparam logic [5:0] op_beq     = 6'b000100;
	localparam logic [5:0] op_bne     = 6'b000101;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_slti    = 6'b001010;
	localparam logic [5:0] op_sltiu   = 6'b001011;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;
	localparam logic [5:0] op_lw      = 6'b100011;
	localparam logic [5:0] op_sw      = 6'b101011;

	// Function codes under op_special
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100;
	localparam logic [5:0] fn_srlv = 6'b000110;
	localparam logic [5:0] fn_srav = 6'b000111;
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_nor  = 6'b100111;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;

endpackage

//--- design/cpu_control.sv
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; #(
	parameter word_t reset_pc = '0
) (
	input  logic         clk,
	input  logic         rst,
	input  word_t        instruction,
	input  word_t        alu_result_now,
	input  logic         alu_zero,
	input  word_t        rs_data,
	output cpu_state_e   state,
	output instr_t       instr,
	output instr_class_e instr_class,
	output alu_op_e      alu_op,
	output logic         alu_b_imm_sel,
	output logic         imm_zero_ext,
	output shift_op_e    shift_op,
	output logic         shift_variable,
	output word_t        pc
);

	cpu_state_e next_state;
	logic       take_branch;
	logic       take_jump;
	word_t      branch_target;
	word_t      jump_target;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_fetch;
		end else begin
			state <= next_state;
		end
	end

	// No-op skips execute, branches finish in execute, stores in memory
	always_comb begin
		case (state)
			st_fetch:   next_state = st_decode;
			st_decode:  next_state = (instr_class == cls_nop) ? st_fetch : st_execute;
			st_execute: begin
				if (instr_class == cls_branch_jump) begin
					next_state = st_fetch;
				end else if (instr_class == cls_load || instr_class == cls_store) begin
					next_state = st_memory;
				end else begin
					next_state = st_writeback;
				end
			end
			st_memory:  next_state = (instr_class == cls_load) ? st_writeback : st_fetch;
			default:    next_state = st_fetch;
		endcase
	end

	// Instruction register, loaded as fetch ends
	always_ff @(posedge clk) begin
		if (state == st_fetch) begin
			instr <= instruction;
		end
	end

	// Decode from the registered word
	always_comb begin
		instr_class    = cls_nop;
		alu_op         = alu_add;
		alu_b_imm_sel  = 1'b0;
		imm_zero_ext   = 1'b0;
		shift_op       = shift_sll;
		shift_variable = 1'b0;
		case (instr.r.opcode)
			op_special: begin
				instr_class = cls_alu_reg;
				case (instr.r.funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_nor:  alu_op = alu_nor;
					fn_slt:  alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav: begin
						// The all-zero word looks like sll but is the no-op
						instr_class    = (instr == '0) ? cls_nop : cls_shift;
						shift_variable = instr.r.funct[2];
						shift_op       = shift_op_e'(instr.r.funct[1:0]);
					end
					default: instr_class = cls_nop;
				endcase
			end
			op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: begin
				instr_class   = cls_alu_imm;
				alu_b_imm_sel = 1'b1;
				// Logic immediates are zero extended
				imm_zero_ext  = instr.i.opcode[2];
				case (instr.i.opcode)
					op_slti:  alu_op = alu_slt;
					op_sltiu: alu_op = alu_sltu;
					op_andi:  alu_op = alu_and;
					op_ori:   alu_op = alu_or;
					op_xori:  alu_op = alu_xor;
					default:  alu_op = alu_add;
				endcase
			end
			op_lui: instr_class = cls_lui;
			op_lw, op_sw: begin
				instr_class   = (instr.i.opcode == op_lw) ? cls_load : cls_store;
				alu_b_imm_sel = 1'b1;
			end
			op_beq, op_bne, op_j: begin
				// Branch compare is rs minus rt, checked through alu_zero
				instr_class = cls_branch_jump;
				alu_op      = alu_sub;
			end
			default: instr_class = cls_nop;
		endcase
	end

	// pc already holds the delay slot address here
	assign branch_target = pc + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
	assign jump_target   = {pc[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};
	assign take_jump     = instr.i.opcode == op_j;
	assign take_branch   = (instr.i.opcode == op_beq && alu_zero) ||
		(instr.i.opcode == op_bne && !alu_zero);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (state == st_fetch) begin
			// ALU gives pc plus 4 during fetch
			pc <= alu_result_now;
		end else if (state == st_execute && instr_class == cls_branch_jump) begin
			if (take_jump) begin
				pc <= jump_target;
			end else if (take_branch) begin
				pc <= branch_target;
			end
		end
	end

	state_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

	pc_word_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

	// Compare against register zero must resolve on rs alone
	branch_vs_zero: assert property (@(posedge clk) disable iff (rst)
		state == st_execute && instr_class == cls_branch_jump && !take_jump &&
		instr.i.rt == '0 |-> alu_zero == (rs_data == '0));

endmodule

//--- design/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import cpu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  cpu_state_e  state,
	input  word_t       pc,
	input  word_t       rs_data,
	input  word_t       rt_data,
	input  logic [15:0] imm,
	input  logic        alu_b_imm_sel,
	input  logic        imm_zero_ext,
	input  alu_op_e     alu_op,
	output word_t       alu_result_now,
	output word_t       alu_result_q,
	output logic        alu_zero
);

	word_t   a_q;
	word_t   b_q;
	alu_op_e op_q;
	word_t   imm_ext;
	word_t   a;
	word_t   b;
	alu_op_e op;

	assign imm_ext = imm_zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};

	always_ff @(posedge clk) begin
		if (rst) begin
			op_q <= alu_add;
		end else if (state == st_decode) begin
			op_q <= alu_op;
		end
	end

	// Operands captured as decode ends
	always_ff @(posedge clk) begin
		if (state == st_decode) begin
			a_q <= rs_data;
			b_q <= alu_b_imm_sel ? imm_ext : rt_data;
		end
	end

	// Fetch borrows the ALU for pc plus 4
	assign a  = (state == st_fetch) ? pc : a_q;
	assign b  = (state == st_fetch) ? word_t'(4) : b_q;
	assign op = (state == st_fetch) ? alu_add : op_q;

	always_comb begin
		case (op)
			alu_and:  alu_result_now = a & b;
			alu_or:   alu_result_now = a | b;
			alu_add:  alu_result_now = a + b;
			alu_sub:  alu_result_now = a - b;
			alu_xor:  alu_result_now = a ^ b;
			alu_nor:  alu_result_now = ~(a | b);
			alu_slt:  alu_result_now = word_t'($signed(a) < $signed(b));
			alu_sltu: alu_result_now = word_t'(a < b);
			default:  alu_result_now = a + b;
		endcase
	end

	// Live flag, used for beq and bne during execute
	assign alu_zero = alu_result_now == '0;

	always_ff @(posedge clk) begin
		if (state == st_execute) begin
			alu_result_q <= alu_result_now;
		end
	end

endmodule

//--- design/shift_unit.sv
`timescale 1ns/1ps

module shift_unit import cpu_pkg::*; (
	input  logic       clk,
	input  cpu_state_e state,
	input  word_t      rt_data,
	input  word_t      rs_data,
	input  reg_addr_t  shamt,
	input  logic       shift_variable,
	input  shift_op_e  shift_op,
	output word_t      shift_result_q
);

	word_t     value_q;
	reg_addr_t amount_q;
	shift_op_e op_q;
	word_t     result;

	// Variable shifts take the low five bits of rs
	always_ff @(posedge clk) begin
		if (state == st_decode) begin
			value_q  <= rt_data;
			amount_q <= shift_variable ? rs_data[4:0] : shamt;
			op_q     <= shift_op;
		end
	end

	always_comb begin
		case (op_q)
			shift_srl: result = value_q >> amount_q;
			shift_sra: result = word_t'($signed(value_q) >>> amount_q);
			default:   result = value_q << amount_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == st_execute) begin
			shift_result_q <= result;
		end
	end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input  logic      clk,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  logic      wen,
	input  reg_addr_t waddr,
	input  word_t     wdata
);

	word_t regs [reg_count];

	// Register zero is never written
	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Reads are combinational, r0 forced to zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	waddr_known: assert property (@(posedge clk) wen |-> !$isunknown(waddr));

endmodule

//--- design/writeback_select.sv
`timescale 1ns/1ps

module writeback_select import cpu_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  cpu_state_e   state,
	input  instr_class_e instr_class,
	input  instr_t       instr,
	input  word_t        alu_result_q,
	input  word_t        shift_result_q,
	input  word_t        read_data,
	output logic         wen,
	output reg_addr_t    waddr,
	output word_t        wdata
);

	word_t load_q;
	logic  writes_reg;

	// Load data held from the memory cycle into write-back
	always_ff @(posedge clk) begin
		if (state == st_memory) begin
			load_q <= read_data;
		end
	end

	always_comb begin
		writes_reg = 1'b1;
		waddr      = instr.i.rt;
		wdata      = alu_result_q;
		case (instr_class)
			cls_alu_reg: waddr = instr.r.rd;
			cls_shift: begin
				waddr = instr.r.rd;
				wdata = shift_result_q;
			end
			cls_alu_imm: wdata = alu_result_q;
			// Immediate into the upper half
			cls_lui:     wdata = {instr.i.imm, 16'b0};
			cls_load:    wdata = load_q;
			default:     writes_reg = 1'b0;
		endcase
	end

	assign wen = writes_reg && state == st_writeback;

	wen_only_in_wb: assert property (@(posedge clk) disable iff (rst)
		wen |-> state == st_writeback);

endmodule

//--- design/simple_cpu.sv
`timescale 1ns/1ps

module simple_cpu import cpu_pkg::*; #(
	parameter word_t reset_pc = '0
) (
	input  logic        clk,
	input  logic        rst,
	output word_t       pc,
	input  word_t       instruction,
	output word_t       address,
	output logic        mem_write,
	output word_t       write_data,
	output logic [3:0]  write_strb,
	input  word_t       read_data,
	output logic        mem_read
);

	cpu_state_e   state;
	instr_t       instr;
	instr_class_e instr_class;
	alu_op_e      alu_op;
	logic         alu_b_imm_sel;
	logic         imm_zero_ext;
	shift_op_e    shift_op;
	logic         shift_variable;
	word_t        alu_result_now;
	word_t        alu_result_q;
	logic         alu_zero;
	word_t        shift_result_q;
	word_t        rs_data;
	word_t        rt_data;
	logic         rf_wen;
	reg_addr_t    rf_waddr;
	word_t        rf_wdata;

	cpu_control #(
		.reset_pc(reset_pc)
	) u_control (
		.clk            (clk),
		.rst            (rst),
		.instruction    (instruction),
		.alu_result_now (alu_result_now),
		.alu_zero       (alu_zero),
		.rs_data        (rs_data),
		.state          (state),
		.instr          (instr),
		.instr_class    (instr_class),
		.alu_op         (alu_op),
		.alu_b_imm_sel  (alu_b_imm_sel),
		.imm_zero_ext   (imm_zero_ext),
		.shift_op       (shift_op),
		.shift_variable (shift_variable),
		.pc             (pc)
	);

	alu_unit u_alu (
		.clk            (clk),
		.rst            (rst),
		.state          (state),
		.pc             (pc),
		.rs_data        (rs_data),
		.rt_data        (rt_data),
		.imm            (instr.i.imm),
		.alu_b_imm_sel  (alu_b_imm_sel),
		.imm_zero_ext   (imm_zero_ext),
		.alu_op         (alu_op),
		.alu_result_now (alu_result_now),
		.alu_result_q   (alu_result_q),
		.alu_zero       (alu_zero)
	);

	shift_unit u_shift (
		.clk            (clk),
		.state          (state),
		.rt_data        (rt_data),
		.rs_data        (rs_data),
		.shamt          (instr.r.shamt),
		.shift_variable (shift_variable),
		.shift_op       (shift_op),
		.shift_result_q (shift_result_q)
	);

	reg_file u_regs (
		.clk    (clk),
		.raddr1 (instr.r.rs),
		.raddr2 (instr.r.rt),
		.rdata1 (rs_data),
		.rdata2 (rt_data),
		.wen    (rf_wen),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata)
	);

	writeback_select u_wb (
		.clk            (clk),
		.rst            (rst),
		.state          (state),
		.instr_class    (instr_class),
		.instr          (instr),
		.alu_result_q   (alu_result_q),
		.shift_result_q (shift_result_q),
		.read_data      (read_data),
		.wen            (rf_wen),
		.waddr          (rf_waddr),
		.wdata          (rf_wdata)
	);

	// Word accesses only, so the byte offset is dropped
	assign address    = {alu_result_q[data_width-1:addr_lsb], {addr_lsb{1'b0}}};
	assign write_data = rt_data;
	assign write_strb = 4'b1111;
	assign mem_read   = state == st_memory && instr_class == cls_load;
	assign mem_write  = state == st_memory && instr_class == cls_store;

	mem_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write));

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 16
) (
	output logic clk,
	output logic rst
);

	// Free running clock, low at time zero
	initial begin
		clk = 1'b0;
		forever begin
			#(period_ns / 2) clk = ~clk;
		end
	end

	// Reset drops on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- tb/simple_cpu_tb.sv
`timescale 1ns/1ps

module simple_cpu_tb import cpu_pkg::*; ();

	localparam word_t reset_pc    = 32'h0000_0100;
	localparam word_t poison_addr = 32'h0000_0E00;
	localparam word_t marker_base = 32'h0000_0F00;
	localparam int    n_tests     = 6;
	localparam int    max_stores  = 64;

	logic       clk;
	logic       rst;
	word_t      pc;
	word_t      instruction;
	word_t      address;
	logic       mem_write;
	word_t      write_data;
	logic [3:0] write_strb;
	word_t      read_data;
	logic       mem_read;

	// Memories, program builder state and reference registers
	word_t       imem [1024];
	word_t       dmem [4096];
	word_t       mreg [32];
	word_t       exp_addr [max_stores];
	word_t       exp_data [max_stores];
	int          exp_test_end [max_stores];
	word_t       exp_load_addr [8];
	int          n_instr = 0;
	int          n_stores = 0;
	int          n_loads = 0;
	word_t       result_addr = 32'h0000_1000;
	logic [15:0] lfsr = 16'd29729;

	// Run progress
	int    store_idx = 0;
	int    load_idx = 0;
	int    error_count = 0;
	int    errors_at_mark = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;
	int    tests_done = 0;
	logic  test_ended = 1'b0;
	int    ended_test = 0;
	logic  built = 1'b0;
	logic  have_prev_fetch = 1'b0;
	logic  prev_was_branch = 1'b0;
	word_t prev_fetch_pc = '0;
	longint watchdog_ns;
	string test_name [n_tests] = '{"reset", "alu", "shift", "load", "branch", "nop"};

	tb_clock_gen #(
		.period_ns    (40),
		.reset_cycles (16)
	) u_clock (
		.clk (clk),
		.rst (rst)
	);

	simple_cpu #(
		.reset_pc(reset_pc)
	) UUT (
		.clk         (clk),
		.rst         (rst),
		.pc          (pc),
		.instruction (instruction),
		.address     (address),
		.mem_write   (mem_write),
		.write_data  (write_data),
		.write_strb  (write_strb),
		.read_data   (read_data),
		.mem_read    (mem_read)
	);

	task automatic note_failure(input string msg);
		error_count++;
		$display("%s (at %0t)", msg, $time);
	endtask

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int count, output word_t value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// Instruction encodings
	function automatic word_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input reg_addr_t shamt, input logic [5:0] funct);
		return {op_special, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_j(input word_t target);
		return {op_j, target[27:2]};
	endfunction

	// Reference results straight from the instruction definitions
	function automatic word_t model_r(input logic [5:0] funct, input word_t a, input word_t b);
		case (funct)
			fn_addu: return a + b;
			fn_subu: return a - b;
			fn_and:  return a & b;
			fn_or:   return a | b;
			fn_xor:  return a ^ b;
			fn_nor:  return ~(a | b);
			fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			fn_sltu: return (a < b) ? 32'd1 : 32'd0;
			default: return 'x;
		endcase
	endfunction

	function automatic word_t model_i(input logic [5:0] op, input word_t a,
		input logic [15:0] imm);
		word_t sext;
		word_t zext;
		sext = {{16{imm[15]}}, imm};
		zext = {16'b0, imm};
		case (op)
			op_addiu: return a + sext;
			op_andi:  return a & zext;
			op_ori:   return a | zext;
			op_xori:  return a ^ zext;
			op_slti:  return ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			op_sltiu: return (a < sext) ? 32'd1 : 32'd0;
			op_lui:   return {imm, 16'b0};
			default:  return 'x;
		endcase
	endfunction

	function automatic word_t model_shift(input logic [5:0] funct, input word_t value,
		input reg_addr_t amount);
		case (funct)
			fn_sll, fn_sllv: return value << amount;
			fn_srl, fn_srlv: return value >> amount;
			default:         return word_t'($signed(value) >>> amount);
		endcase
	endfunction

	function automatic logic is_branch(input word_t w);
		return w[31:26] == op_beq || w[31:26] == op_bne || w[31:26] == op_j;
	endfunction

	// Each program builder step also updates the reference registers
	task automatic put(input word_t w);
		imem[(reset_pc >> 2) + n_instr] = w;
		n_instr++;
	endtask

	task automatic alu_r(input logic [5:0] funct, input reg_addr_t rd, input reg_addr_t rs,
		input reg_addr_t rt);
		put(enc_r(rs, rt, rd, 5'd0, funct));
		if (rd != 0) begin
			mreg[rd] = model_r(funct, mreg[rs], mreg[rt]);
		end
	endtask

	task automatic alu_i(input logic [5:0] op, input reg_addr_t rt, input reg_addr_t rs,
		input logic [15:0] imm);
		put(enc_i(op, rs, rt, imm));
		if (rt != 0) begin
			mreg[rt] = model_i(op, mreg[rs], imm);
		end
	endtask

	task automatic do_shift(input logic [5:0] funct, input reg_addr_t rd, input reg_addr_t rt,
		input reg_addr_t rs, input reg_addr_t shamt);
		logic variable;
		variable = funct == fn_sllv || funct == fn_srlv || funct == fn_srav;
		if (variable) begin
			put(enc_r(rs, rt, rd, 5'd0, funct));
			mreg[rd] = model_shift(funct, mreg[rt], mreg[rs][4:0]);
		end else begin
			put(enc_r(5'd0, rt, rd, shamt, funct));
			mreg[rd] = model_shift(funct, mreg[rt], shamt);
		end
	endtask

	task automatic set_reg(input reg_addr_t r, input word_t value);
		alu_i(op_lui, r, 5'd0, value[31:16]);
		alu_i(op_ori, r, r, value[15:0]);
	endtask

	task automatic store_word(input reg_addr_t rt, input word_t addr);
		put(enc_i(op_sw, 5'd0, rt, addr[15:0]));
		exp_addr[n_stores] = addr;
		exp_data[n_stores] = mreg[rt];
		exp_test_end[n_stores] = -1;
		n_stores++;
	endtask

	task automatic store_result(input reg_addr_t rt);
		store_word(rt, result_addr);
		result_addr += 4;
	endtask

	// Store that must never execute
	task automatic poison_store();
		put(enc_i(op_sw, 5'd0, 5'd1, poison_addr[15:0]));
	endtask

	task automatic load_word(input reg_addr_t rt, input reg_addr_t base,
		input logic [15:0] off, input word_t value);
		word_t addr;
		addr = mreg[base] + {{16{off[15]}}, off};
		dmem[addr[13:2]] = value;
		put(enc_i(op_lw, base, rt, off));
		mreg[rt] = value;
		exp_load_addr[n_loads] = addr;
		n_loads++;
	endtask

	// Branch over the next instruction when taken
	task automatic branch(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt);
		put(enc_i(op, rs, rt, 16'd1));
	endtask

	// Test id goes to the test's own marker word
	task automatic end_test(input int id);
		alu_i(op_addiu, 5'd1, 5'd0, 16'(id));
		store_word(5'd1, marker_base + 4 * id);
		exp_test_end[n_stores - 1] = id;
	endtask

	task automatic build_program();
		word_t      v;
		logic [5:0] r_funct [8];
		logic [5:0] i_op [6];
		logic [5:0] s_funct [6];
		r_funct = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
		i_op = '{op_addiu, op_andi, op_ori, op_xori, op_slti, op_sltiu};
		s_funct = '{fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
		// Unused code words jump to themselves and data words carry their address
		for (int i = 0; i < 1024; i++) begin
			imem[i] = enc_j(i * 4);
		end
		for (int i = 0; i < 4096; i++) begin
			dmem[i] = 32'h5A5A_0000 ^ (i << 2);
		end
		foreach (mreg[i]) begin
			mreg[i] = '0;
		end
		end_test(0);
		// Third operand takes the opposite sign to split slt from sltu
		random_bits(32, v);
		set_reg(8, v);
		random_bits(32, v);
		set_reg(9, v);
		random_bits(31, v);
		set_reg(11, {~mreg[8][31], v[30:0]});
		foreach (r_funct[k]) begin
			alu_r(r_funct[k], 10, 8, 9);
			store_result(10);
		end
		alu_r(fn_slt, 10, 8, 11);
		store_result(10);
		alu_r(fn_sltu, 10, 8, 11);
		store_result(10);
		foreach (i_op[k]) begin
			random_bits(16, v);
			alu_i(i_op[k], 10, 8, v[15:0]);
			store_result(10);
		end
		random_bits(16, v);
		alu_i(op_lui, 10, 0, v[15:0]);
		store_result(10);
		end_test(1);
		// Negative value so sra fills with ones
		random_bits(31, v);
		set_reg(12, {1'b1, v[30:0]});
		random_bits(32, v);
		set_reg(13, v);
		foreach (s_funct[k]) begin
			random_bits(5, v);
			do_shift(s_funct[k], 14, 12, 13, v[4:0]);
			store_result(14);
		end
		end_test(2);
		random_bits(32, v);
		load_word(14, 0, 16'h0D40, v);
		random_bits(16, v);
		alu_i(op_addiu, 15, 14, v[15:0]);
		store_result(15);
		// Second load through a base register
		set_reg(20, 32'h0000_0D00);
		random_bits(32, v);
		load_word(14, 20, 16'h0084, v);
		alu_r(fn_addu, 15, 14, 9);
		store_result(15);
		end_test(3);
		random_bits(32, v);
		set_reg(16, v);
		set_reg(17, v);
		set_reg(18, ~v);
		branch(op_beq, 16, 17);
		poison_store();
		branch(op_beq, 16, 18);
		store_result(16);
		branch(op_bne, 16, 18);
		poison_store();
		branch(op_bne, 16, 17);
		store_result(17);
		put(enc_j(reset_pc + 4 * (n_instr + 2)));
		poison_store();
		end_test(4);
		put('0);
		put('0);
		alu_i(op_addiu, 10, 9, 16'h0004);
		put('0);
		store_result(10);
		end_test(5);
		// Park the CPU
		put(enc_j(reset_pc + 4 * n_instr));
	endtask

	// Memory model answers on the falling edge
	always @(negedge clk) begin
		instruction <= imem[pc[11:2]];
		read_data <= dmem[address[13:2]];
	end

	always @(posedge clk) begin
		test_ended <= 1'b0;
		if (!rst && mem_write) begin
			if (store_idx < n_stores && exp_test_end[store_idx] >= 0) begin
				test_ended <= 1'b1;
				ended_test <= exp_test_end[store_idx];
			end
			dmem[address[13:2]] = write_data;
			store_idx <= store_idx + 1;
		end
		if (!rst && mem_read) begin
			load_idx <= load_idx + 1;
		end
	end

	// Remember the last fetch for the pc step check
	always @(posedge clk) begin
		if (rst) begin
			have_prev_fetch <= 1'b0;
		end else if (UUT.state == st_fetch) begin
			have_prev_fetch <= 1'b1;
			prev_fetch_pc <= pc;
			prev_was_branch <= is_branch(instruction);
		end
	end

	// One line per finished test
	always @(negedge clk) begin
		if (test_ended) begin
			if (error_count == errors_at_mark) begin
				tests_passed++;
				$display("test %0d %s: ok", ended_test, test_name[ended_test]);
			end else begin
				tests_failed++;
				$display("test %0d %s: %0d checks failed", ended_test,
					test_name[ended_test], error_count - errors_at_mark);
			end
			errors_at_mark = error_count;
			tests_done++;
		end
	end

	reset_pc_hold: assert property (@(posedge clk) rst |=> pc == reset_pc)
		else note_failure($sformatf("mismatch pc expected %h actual %h", reset_pc,
			$sampled(pc)));

	reset_mem_idle: assert property (@(posedge clk) rst |=> !mem_read && !mem_write)
		else note_failure("memory access during or right after reset");

	first_fetch: assert property (@(posedge clk) $fell(rst) |-> pc == reset_pc)
		else note_failure($sformatf("mismatch pc expected %h actual %h", reset_pc,
			$sampled(pc)));

	store_expected: assert property (@(posedge clk) disable iff (rst)
		mem_write |-> store_idx < n_stores)
		else note_failure("store made after the last expected one");

	store_address: assert property (@(posedge clk) disable iff (rst)
		mem_write && store_idx < n_stores |-> address == exp_addr[store_idx])
		else note_failure($sformatf("mismatch address expected %h actual %h",
			exp_addr[$sampled(store_idx)], $sampled(address)));

	store_data: assert property (@(posedge clk) disable iff (rst)
		mem_write && store_idx < n_stores |-> write_data == exp_data[store_idx])
		else note_failure($sformatf("mismatch write_data expected %h actual %h",
			exp_data[$sampled(store_idx)], $sampled(write_data)));

	store_strobe: assert property (@(posedge clk) disable iff (rst)
		mem_write |-> write_strb == 4'hf)
		else note_failure($sformatf("mismatch write_strb expected %h actual %h", 4'hf,
			$sampled(write_strb)));

	no_poison: assert property (@(posedge clk) disable iff (rst)
		mem_write |-> address != poison_addr)
		else note_failure("a skipped store reached the poison address");

	load_expected: assert property (@(posedge clk) disable iff (rst)
		mem_read |-> load_idx < n_loads)
		else note_failure("load made after the last expected one");

	load_address: assert property (@(posedge clk) disable iff (rst)
		mem_read && load_idx < n_loads |-> address == exp_load_addr[load_idx])
		else note_failure($sformatf("mismatch address expected %h actual %h",
			exp_load_addr[$sampled(load_idx)], $sampled(address)));

	// A load reads memory in the third cycle after its fetch and in no other
	load_one_cycle: assert property (@(posedge clk) disable iff (rst)
		UUT.state == st_fetch && instruction[31:26] == op_lw |->
		!mem_read ##1 !mem_read ##1 !mem_read ##1 mem_read ##1 !mem_read)
		else note_failure("mem_read was not high for exactly the load's memory cycle");

	// No-op fetch is followed by one decode cycle and then the next word
	nop_timing: assert property (@(posedge clk) disable iff (rst)
		UUT.state == st_fetch && instruction == '0 |=>
		UUT.state != st_fetch ##1 (UUT.state == st_fetch && pc == $past(pc, 2) + 4))
		else note_failure("no-op was not followed by a fetch of the next word 2 cycles later");

	pc_step: assert property (@(posedge clk) disable iff (rst)
		UUT.state == st_fetch && have_prev_fetch && !prev_was_branch |->
		pc == prev_fetch_pc + 4)
		else note_failure($sformatf("mismatch pc expected %h actual %h",
			$sampled(prev_fetch_pc) + 4, $sampled(pc)));

	initial begin
		instruction = '0;
		read_data = '0;
		build_program();
		built = 1'b1;
		wait (tests_done == n_tests);
		repeat (2) @(posedge clk);
		assert (store_idx == n_stores)
			else note_failure($sformatf("%0d stores seen where %0d were expected",
				store_idx, n_stores));
		assert (load_idx == n_loads)
			else note_failure($sformatf("%0d loads seen where %0d were expected",
				load_idx, n_loads));
		$display("%0d tests passed, %0d tests failed, %0d failed checks", tests_passed,
			tests_failed, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Doubled worst case of five cycles per instruction plus the reset time
	initial begin
		wait (built);
		watchdog_ns = longint'(n_instr) * 5 * 40 * 2 + 16 * 40;
		#(watchdog_ns);
		$display("timeout: program did not finish within %0d ns", watchdog_ns);
		$display("Test failed");
		$finish;
	end

endmodule

//--- filelist.f
design/cpu_pkg.sv
design/cpu_control.sv
design/alu_unit.sv
design/shift_unit.sv
design/reg_file.sv
design/writeback_select.sv
design/simple_cpu.sv
tb/tb_clock_gen.sv
tb/simple_cpu_tb.sv
